// ==== Bender.yml ====
package:
  name: mem_uart

sources:
  - src/uart_pkg.sv
  - src/mem_pkg.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/mem_uart.sv
  - src/mem_arbiter.sv
  - src/mem_uart_top.sv
  - target: test
    files:
      - verif/mem_uart_assertions.sv
      - verif/mem_uart_tb.sv

// ==== build.f ====
src/uart_pkg.sv
src/mem_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/mem_uart.sv
src/mem_arbiter.sv
src/mem_uart_top.sv
verif/mem_uart_assertions.sv
verif/mem_uart_tb.sv

// ==== src/mem_arbiter.sv ====
////////////////////
// Round-robin arbiter for the two memory clients
////////////////////
module mem_arbiter
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  nRst,
   input  logic [ADDR_WIDTH-1:0] i_c0_addr,
   input  logic [DATA_WIDTH-1:0] i_c0_wdata,
   input  logic                  i_c0_read_valid,
   input  logic                  i_c0_write_valid,
   output logic                  o_c0_read_accept,
   output logic                  o_c0_write_accept,
   output logic [DATA_WIDTH-1:0] o_c0_rdata,
   input  logic [ADDR_WIDTH-1:0] i_c1_addr,
   input  logic [DATA_WIDTH-1:0] i_c1_wdata,
   input  logic                  i_c1_read_valid,
   input  logic                  i_c1_write_valid,
   output logic                  o_c1_read_accept,
   output logic                  o_c1_write_accept,
   output logic [DATA_WIDTH-1:0] o_c1_rdata,
   output logic [ADDR_WIDTH-1:0] o_addr,
   output logic [DATA_WIDTH-1:0] o_wdata,
   output logic                  o_read_valid,
   output logic                  o_write_valid,
   input  logic                  i_read_accept,
   input  logic                  i_write_accept,
   input  logic [DATA_WIDTH-1:0] i_rdata,
   input  logic                  i_busy
);

   logic [CLIENT_W-1:0] grant;
   logic [CLIENT_W-1:0] last_served;
   logic                active;
   logic                c0_req;
   logic                c1_req;
   logic                pick_c1;
   logic                gnt_c1;

   assign c0_req  = i_c0_read_valid | i_c0_write_valid;
   assign c1_req  = i_c1_read_valid | i_c1_write_valid;
   // On a tie the client not served last wins
   assign pick_c1 = c1_req && (!c0_req || last_served == '0);
   assign gnt_c1  = (grant == CLIENT_W'(1));

   // Grant held from selection until the bridge accepts
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         grant       <= '0;
         last_served <= CLIENT_W'(1);
         active      <= 1'b0;
      end else if (active) begin
         if (i_read_accept || i_write_accept) begin
            active      <= 1'b0;
            last_served <= grant;
         end
      end else if (!i_busy && (c0_req || c1_req)) begin
         active <= 1'b1;
         grant  <= pick_c1 ? CLIENT_W'(1) : '0;
      end
   end

   assign o_addr        = gnt_c1 ? i_c1_addr : i_c0_addr;
   assign o_wdata       = gnt_c1 ? i_c1_wdata : i_c0_wdata;
   assign o_read_valid  = active && (gnt_c1 ? i_c1_read_valid : i_c0_read_valid);
   assign o_write_valid = active && (gnt_c1 ? i_c1_write_valid : i_c0_write_valid);

   assign o_c0_read_accept  = i_read_accept && !gnt_c1;
   assign o_c0_write_accept = i_write_accept && !gnt_c1;
   assign o_c1_read_accept  = i_read_accept && gnt_c1;
   assign o_c1_write_accept = i_write_accept && gnt_c1;
   assign o_c0_rdata        = gnt_c1 ? '0 : i_rdata;
   assign o_c1_rdata        = gnt_c1 ? i_rdata : '0;

endmodule

// ==== src/mem_pkg.sv ====
////////////////////
// Memory widths, nibble counts and client count
////////////////////
package mem_pkg;

   localparam int NIBBLE_BITS   = 4;
   localparam int DATA_NIBBLES  = 4;
   localparam int ADDR_NIBBLES  = 4;

   localparam int DATA_WIDTH    = DATA_NIBBLES * NIBBLE_BITS;
   localparam int ADDR_WIDTH    = ADDR_NIBBLES * NIBBLE_BITS;

   // Word on the link is {addr, data}, data in the low nibbles
   localparam int TOTAL_NIBBLES = DATA_NIBBLES + ADDR_NIBBLES;
   localparam int NIB_PTR_W     = $clog2(TOTAL_NIBBLES);
   localparam int RX_PTR_W      = $clog2(DATA_NIBBLES);

   localparam int NUM_CLIENTS   = 2;
   localparam int CLIENT_W      = $clog2(NUM_CLIENTS);

endpackage

// ==== src/mem_uart.sv ====
////////////////////
// Request sequencer, memory access to tagged UART bytes and back
////////////////////
module mem_uart
   import uart_pkg::*;
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  nRst,
   input  logic [ADDR_WIDTH-1:0] i_addr,
   input  logic [DATA_WIDTH-1:0] i_wdata,
   input  logic                  i_read_valid,
   input  logic                  i_write_valid,
   output logic                  o_read_accept,
   output logic                  o_write_accept,
   output logic [DATA_WIDTH-1:0] o_rdata,
   output logic [BYTE_BITS-1:0]  o_tx_data,
   output logic                  o_tx_valid,
   input  logic                  i_tx_accept,
   input  logic [BYTE_BITS-1:0]  i_rx_data,
   input  logic                  i_rx_valid,
   output logic                  o_busy
);

   typedef enum logic [2:0] {
      IDLE,
      SEND,
      WAIT_TX,
      RECV,
      DONE
   } seq_state_t;

   seq_state_t                       state;
   logic                             is_write;
   logic [ADDR_WIDTH+DATA_WIDTH-1:0] word_q;
   logic [NIB_PTR_W-1:0]             tx_ptr;
   logic [RX_PTR_W-1:0]              rx_ptr;
   logic [FRAME_CNT_W-1:0]           wait_cnt;
   logic [NIBBLE_BITS-1:0]           tx_nibble;
   frame_cmd_t                       tx_tag;
   frame_cmd_t                       rx_tag;
   frame_cmd_t                       rx_expect;
   logic                             start_req;
   logic                             tx_last;
   logic                             rx_match;

   ////////////////////
   // Byte out

   assign start_req = (state == IDLE) && (i_write_valid || i_read_valid);
   assign tx_nibble = word_q[tx_ptr*NIBBLE_BITS +: NIBBLE_BITS];
   assign tx_last   = (tx_ptr == NIB_PTR_W'(TOTAL_NIBBLES - 1));

   // Tag from nibble position and access type
   always_comb begin
      if (tx_last) begin
         tx_tag = is_write ? CMD_END_WRITE : CMD_END_READ;
      end else if (tx_ptr == '0) begin
         tx_tag = CMD_DATA_START;
      end else if (tx_ptr == NIB_PTR_W'(DATA_NIBBLES)) begin
         tx_tag = CMD_ADDR_START;
      end else begin
         tx_tag = CMD_CONT;
      end
   end

   assign o_tx_data  = {tx_tag, tx_nibble};
   assign o_tx_valid = (state == SEND);

   ////////////////////
   // Reply in

   assign rx_tag    = frame_cmd_t'(i_rx_data[BYTE_BITS-1:NIBBLE_BITS]);
   assign rx_expect = (rx_ptr == '0) ? CMD_DATA_START : CMD_CONT;
   assign rx_match  = i_rx_valid && (rx_tag == rx_expect);

   assign o_busy         = (state != IDLE);
   assign o_read_accept  = (state == DONE) && !is_write;
   assign o_write_accept = (state == DONE) && is_write;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state    <= IDLE;
         is_write <= 1'b0;
         tx_ptr   <= '0;
         rx_ptr   <= '0;
         wait_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start_req) begin
                  is_write <= i_write_valid;
                  // A read sends the address nibbles only
                  tx_ptr   <= i_write_valid ? '0 : NIB_PTR_W'(DATA_NIBBLES);
                  state    <= SEND;
               end
            end
            SEND: begin
               if (i_tx_accept) begin
                  if (tx_last) begin
                     wait_cnt <= '0;
                     rx_ptr   <= '0;
                     state    <= is_write ? WAIT_TX : RECV;
                  end else begin
                     tx_ptr <= tx_ptr + 1'b1;
                  end
               end
            end
            WAIT_TX: begin
               // Last byte fully on the line before the write completes
               if (wait_cnt == FRAME_CNT_W'(FRAME_CLKS - 1)) begin
                  state <= DONE;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            RECV: begin
               if (rx_match) begin
                  if (rx_ptr == RX_PTR_W'(DATA_NIBBLES - 1)) begin
                     state <= DONE;
                  end else begin
                     rx_ptr <= rx_ptr + 1'b1;
                  end
               end
            end
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start_req) begin
         word_q <= {i_addr, i_wdata};
      end
      if (state == RECV && rx_match) begin
         o_rdata[rx_ptr*NIBBLE_BITS +: NIBBLE_BITS] <= i_rx_data[NIBBLE_BITS-1:0];
      end
   end

endmodule

// ==== src/mem_uart_top.sv ====
////////////////////
// Memory emulator bridge top, arbiter, sequencer and UART
////////////////////
module mem_uart_top
   import uart_pkg::*;
   import mem_pkg::*;
(
   input  logic                  clk,
   input  logic                  nRst,
   input  logic [ADDR_WIDTH-1:0] i_c0_addr,
   input  logic [DATA_WIDTH-1:0] i_c0_wdata,
   input  logic                  i_c0_read_valid,
   input  logic                  i_c0_write_valid,
   output logic                  o_c0_read_accept,
   output logic                  o_c0_write_accept,
   output logic [DATA_WIDTH-1:0] o_c0_rdata,
   input  logic [ADDR_WIDTH-1:0] i_c1_addr,
   input  logic [DATA_WIDTH-1:0] i_c1_wdata,
   input  logic                  i_c1_read_valid,
   input  logic                  i_c1_write_valid,
   output logic                  o_c1_read_accept,
   output logic                  o_c1_write_accept,
   output logic [DATA_WIDTH-1:0] o_c1_rdata,
   input  logic                  i_rx,
   output logic                  o_tx
);

   // Arbiter to bridge
   logic [ADDR_WIDTH-1:0] br_addr;
   logic [DATA_WIDTH-1:0] br_wdata;
   logic                  br_read_valid;
   logic                  br_write_valid;
   logic                  br_read_accept;
   logic                  br_write_accept;
   logic [DATA_WIDTH-1:0] br_rdata;
   logic                  br_busy;

   // Bridge to UART
   logic [BYTE_BITS-1:0]  tx_data;
   logic                  tx_valid;
   logic                  tx_accept;
   logic [BYTE_BITS-1:0]  rx_data;
   logic                  rx_valid;

   mem_arbiter mem_arbiter_i (
      .clk               (clk),
      .nRst              (nRst),
      .i_c0_addr         (i_c0_addr),
      .i_c0_wdata        (i_c0_wdata),
      .i_c0_read_valid   (i_c0_read_valid),
      .i_c0_write_valid  (i_c0_write_valid),
      .o_c0_read_accept  (o_c0_read_accept),
      .o_c0_write_accept (o_c0_write_accept),
      .o_c0_rdata        (o_c0_rdata),
      .i_c1_addr         (i_c1_addr),
      .i_c1_wdata        (i_c1_wdata),
      .i_c1_read_valid   (i_c1_read_valid),
      .i_c1_write_valid  (i_c1_write_valid),
      .o_c1_read_accept  (o_c1_read_accept),
      .o_c1_write_accept (o_c1_write_accept),
      .o_c1_rdata        (o_c1_rdata),
      .o_addr            (br_addr),
      .o_wdata           (br_wdata),
      .o_read_valid      (br_read_valid),
      .o_write_valid     (br_write_valid),
      .i_read_accept     (br_read_accept),
      .i_write_accept    (br_write_accept),
      .i_rdata           (br_rdata),
      .i_busy            (br_busy)
   );

   mem_uart mem_uart_i (
      .clk            (clk),
      .nRst           (nRst),
      .i_addr         (br_addr),
      .i_wdata        (br_wdata),
      .i_read_valid   (br_read_valid),
      .i_write_valid  (br_write_valid),
      .o_read_accept  (br_read_accept),
      .o_write_accept (br_write_accept),
      .o_rdata        (br_rdata),
      .o_tx_data      (tx_data),
      .o_tx_valid     (tx_valid),
      .i_tx_accept    (tx_accept),
      .i_rx_data      (rx_data),
      .i_rx_valid     (rx_valid),
      .o_busy         (br_busy)
   );

   uart_tx uart_tx_i (
      .clk      (clk),
      .nRst     (nRst),
      .i_data   (tx_data),
      .i_valid  (tx_valid),
      .o_accept (tx_accept),
      .o_tx     (o_tx)
   );

   uart_rx uart_rx_i (
      .clk     (clk),
      .nRst    (nRst),
      .i_rx    (i_rx),
      .o_data  (rx_data),
      .o_valid (rx_valid)
   );

endmodule

// ==== src/uart_pkg.sv ====
////////////////////
// UART bit timing, frame sizes and the command tags of each link byte
////////////////////
package uart_pkg;

   // Clock cycles per serial bit, stands in for clock rate over baud
   localparam int CLKS_PER_BIT = 8;
   localparam int BYTE_BITS    = 8;

   // Start bit, data bits, stop bit
   localparam int FRAME_BITS   = BYTE_BITS + 2;
   localparam int FRAME_CLKS   = FRAME_BITS * CLKS_PER_BIT;

   localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);
   localparam int FRAME_CNT_W  = $clog2(FRAME_CLKS);

   // Tag in bits 7:4 of every byte, payload nibble in bits 3:0
   // Zero marks a continuation nibble, the others are one-hot
   typedef enum logic [3:0] {
      CMD_CONT       = 4'b0000,
      CMD_END_READ   = 4'b0001,
      CMD_END_WRITE  = 4'b0010,
      CMD_ADDR_START = 4'b0100,
      CMD_DATA_START = 4'b1000
   } frame_cmd_t;

endpackage

// ==== src/uart_rx.sv ====
////////////////////
// Oversampled UART receiver
////////////////////
module uart_rx
   import uart_pkg::*;
(
   input  logic                 clk,
   input  logic                 nRst,
   input  logic                 i_rx,
   output logic [BYTE_BITS-1:0] o_data,
   output logic                 o_valid
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                    state;
   logic [1:0]                   rx_sync;
   logic [BIT_CNT_W-1:0]         clk_cnt;
   logic [$clog2(BYTE_BITS)-1:0] bit_idx;
   logic [BYTE_BITS-1:0]         shift_q;
   logic                         rx_bit;
   logic                         bit_mid;

   assign rx_bit  = rx_sync[1];
   assign bit_mid = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
   assign o_data  = shift_q;

   // Two flop synchroniser, line idles high
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], i_rx};
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state   <= RX_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         clk_cnt <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!rx_bit) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               // Recheck half a bit in, a glitch goes back to idle
               if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state   <= rx_bit ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (bit_mid) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == ($clog2(BYTE_BITS))'(BYTE_BITS - 1)) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (bit_mid) begin
                  // Framing error drops the byte
                  o_valid <= rx_bit;
                  state   <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_mid) begin
         shift_q <= {rx_bit, shift_q[BYTE_BITS-1:1]};
      end
   end

endmodule

// ==== src/uart_tx.sv ====
////////////////////
// UART transmitter with valid/accept byte input
////////////////////
module uart_tx
   import uart_pkg::*;
(
   input  logic                 clk,
   input  logic                 nRst,
   input  logic [BYTE_BITS-1:0] i_data,
   input  logic                 i_valid,
   output logic                 o_accept,
   output logic                 o_tx
);

   typedef enum logic {
      TX_IDLE,
      TX_SHIFT
   } tx_state_t;

   tx_state_t                     state;
   logic [BIT_CNT_W-1:0]          clk_cnt;
   logic [$clog2(FRAME_BITS)-1:0] bit_cnt;
   // Data bits plus the stop bit behind them
   logic [BYTE_BITS:0]            shift_q;
   logic                          bit_end;
   logic                          frame_end;

   assign o_accept  = (state == TX_IDLE) && i_valid;
   assign bit_end   = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
   assign frame_end = (bit_cnt == ($clog2(FRAME_BITS))'(FRAME_BITS - 1));

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state   <= TX_IDLE;
         clk_cnt <= '0;
         bit_cnt <= '0;
         o_tx    <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               if (o_accept) begin
                  // Start bit goes out right away
                  state   <= TX_SHIFT;
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  o_tx    <= 1'b0;
               end
            end
            TX_SHIFT: begin
               clk_cnt <= clk_cnt + 1'b1;
               if (bit_end) begin
                  clk_cnt <= '0;
                  if (frame_end) begin
                     state <= TX_IDLE;
                  end else begin
                     o_tx    <= shift_q[0];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (o_accept) begin
         shift_q <= {1'b1, i_data};
      end else if (state == TX_SHIFT && bit_end && !frame_end) begin
         shift_q <= {1'b1, shift_q[BYTE_BITS:1]};
      end
   end

endmodule

// ==== verif/mem_uart_assertions.sv ====
////////////////////
// Client handshake and serial idle assertions, bound to the top level
////////////////////
module mem_uart_assertions (
   input logic clk,
   input logic nRst,
   input logic i_c0_read_valid,
   input logic i_c0_write_valid,
   input logic o_c0_read_accept,
   input logic o_c0_write_accept,
   input logic i_c1_read_valid,
   input logic i_c1_write_valid,
   input logic o_c1_read_accept,
   input logic o_c1_write_accept,
   input logic o_tx
);

   logic c0_acc;
   logic c1_acc;
   logic seen_req;
   // Number of assertion failures so far
   int   fail_cnt = 0;

   assign c0_acc = o_c0_read_accept | o_c0_write_accept;
   assign c1_acc = o_c1_read_accept | o_c1_write_accept;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         seen_req <= 1'b0;
      end else if (i_c0_read_valid | i_c0_write_valid | i_c1_read_valid | i_c1_write_valid) begin
         seen_req <= 1'b1;
      end
   end

   // Each accept needs its own valid
   a_c0_rd: assert property (@(posedge clk) disable iff (!nRst)
      o_c0_read_accept |-> i_c0_read_valid)
      else begin
         $error("c0 read accept without valid");
         fail_cnt++;
      end
   a_c0_wr: assert property (@(posedge clk) disable iff (!nRst)
      o_c0_write_accept |-> i_c0_write_valid)
      else begin
         $error("c0 write accept without valid");
         fail_cnt++;
      end
   a_c1_rd: assert property (@(posedge clk) disable iff (!nRst)
      o_c1_read_accept |-> i_c1_read_valid)
      else begin
         $error("c1 read accept without valid");
         fail_cnt++;
      end
   a_c1_wr: assert property (@(posedge clk) disable iff (!nRst)
      o_c1_write_accept |-> i_c1_write_valid)
      else begin
         $error("c1 write accept without valid");
         fail_cnt++;
      end

   a_pulse: assert property (@(posedge clk) disable iff (!nRst)
      (c0_acc | c1_acc) |=> !(c0_acc | c1_acc))
      else begin
         $error("accept longer than one cycle");
         fail_cnt++;
      end
   a_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(c0_acc && c1_acc))
      else begin
         $error("both clients accepted together");
         fail_cnt++;
      end
   a_idle: assert property (@(posedge clk) disable iff (!nRst)
      !seen_req |-> o_tx)
      else begin
         $error("serial line left idle before any request");
         fail_cnt++;
      end

endmodule

// ==== verif/mem_uart_tb.sv ====
////////////////////
// Bridge testbench with host UART model, memory model and scoreboard
////////////////////
module mem_uart_tb
   import uart_pkg::*;
   import mem_pkg::*;
();

   localparam int TIMEOUT = 4000;

   logic                  clk = 1'b0;
   logic                  nRst;
   logic                  i_rx;
   logic                  o_tx;
   logic [ADDR_WIDTH-1:0] c_addr [2];
   logic [DATA_WIDTH-1:0] c_wdata [2];
   logic                  c_rv [2];
   logic                  c_wv [2];
   logic                  rd_acc [2];
   logic                  wr_acc [2];
   logic [DATA_WIDTH-1:0] c_rdata [2];

   logic [31:0]           lcg_state = 32'hd3cf;
   int                    errors = 0;
   int                    tests_run = 0;
   int                    tests_failed = 0;
   bit                    corrupt_next = 0;

   // Host side state
   logic [7:0]            tx_bytes [$];
   logic [7:0]            reply_q [$];
   logic [DATA_WIDTH-1:0] host_mem [logic [ADDR_WIDTH-1:0]];
   // Decoded frames waiting for their accept
   bit                    fr_wr [$];
   logic [ADDR_WIDTH-1:0] fr_addr [$];
   logic [DATA_WIDTH-1:0] fr_data [$];
   // Scoreboard memory, updated on write accepts
   logic [DATA_WIDTH-1:0] ref_mem [logic [ADDR_WIDTH-1:0]];
   int                    acc_order [$];

   always #2 clk = ~clk;

   mem_uart_top mem_uart_top_i (
      .clk               (clk),
      .nRst              (nRst),
      .i_c0_addr         (c_addr[0]),
      .i_c0_wdata        (c_wdata[0]),
      .i_c0_read_valid   (c_rv[0]),
      .i_c0_write_valid  (c_wv[0]),
      .o_c0_read_accept  (rd_acc[0]),
      .o_c0_write_accept (wr_acc[0]),
      .o_c0_rdata        (c_rdata[0]),
      .i_c1_addr         (c_addr[1]),
      .i_c1_wdata        (c_wdata[1]),
      .i_c1_read_valid   (c_rv[1]),
      .i_c1_write_valid  (c_wv[1]),
      .o_c1_read_accept  (rd_acc[1]),
      .o_c1_write_accept (wr_acc[1]),
      .o_c1_rdata        (c_rdata[1]),
      .i_rx              (i_rx),
      .o_tx              (o_tx)
   );

   bind mem_uart_top mem_uart_assertions mem_uart_assertions_i (.*);

   // Upper half only, the low bits of an LCG repeat with a short period
   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   task automatic finish_run();
      int asrt_fails;
      asrt_fails = mem_uart_top_i.mem_uart_assertions_i.fail_cnt;
      $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   ////////////////////
   // Host model, frame decode

   task automatic check_frame(input bit wr);
      int                    n;
      logic [3:0]            exp_tag;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
      n = wr ? 8 : 4;
      assert (tx_bytes.size() == n) else begin
         $display("FAILED %0t: frame has %0d bytes, expected %0d", $time, tx_bytes.size(), n);
         errors++;
      end
      for (int i = 0; i < tx_bytes.size() && i < n; i++) begin
         if (i == n - 1) exp_tag = wr ? CMD_END_WRITE : CMD_END_READ;
         else if (wr && i == 0) exp_tag = CMD_DATA_START;
         else if (i == n - ADDR_NIBBLES) exp_tag = CMD_ADDR_START;
         else exp_tag = CMD_CONT;
         assert (tx_bytes[i][7:4] == exp_tag) else begin
            $display("FAILED %0t: byte %0d tag %h, expected %h", $time, i, tx_bytes[i][7:4],
                     exp_tag);
            errors++;
         end
         if (wr && i < DATA_NIBBLES) data[i*4 +: 4] = tx_bytes[i][3:0];
         else addr[(i - (n - ADDR_NIBBLES))*4 +: 4] = tx_bytes[i][3:0];
      end
      fr_wr.push_back(wr);
      fr_addr.push_back(addr);
      fr_data.push_back(data);
      if (wr) begin
         host_mem[addr] = data;
      end else begin
         data = host_mem.exists(addr) ? host_mem[addr] : '0;
         if (corrupt_next) begin
            // Wrong tag for the first reply nibble
            reply_q.push_back({CMD_ADDR_START, 4'hf});
            corrupt_next = 0;
         end
         for (int i = 0; i < DATA_NIBBLES; i++) begin
            reply_q.push_back({(i == 0) ? CMD_DATA_START : CMD_CONT, data[i*4 +: 4]});
         end
      end
      tx_bytes.delete();
   endtask

   int         mon_cnt;
   bit         mon_busy = 0;
   logic [7:0] mon_byte;

   // Samples o_tx at mid bit, count runs from the first low sample
   always @(posedge clk) begin
      if (!mon_busy) begin
         if (nRst && !o_tx) begin
            mon_busy = 1;
            mon_cnt  = 0;
         end
      end else begin
         mon_cnt++;
         if (mon_cnt >= 12 && mon_cnt < 76 && mon_cnt % CLKS_PER_BIT == 4) begin
            mon_byte[(mon_cnt - 12) / CLKS_PER_BIT] = o_tx;
         end
         if (mon_cnt == 76) begin
            mon_busy = 0;
            assert (o_tx) else begin
               $display("FAILED %0t: stop bit low on o_tx", $time);
               errors++;
            end
            tx_bytes.push_back(mon_byte);
            if (mon_byte[7:4] == CMD_END_WRITE || mon_byte[7:4] == CMD_END_READ) begin
               check_frame(mon_byte[7:4] == CMD_END_WRITE);
            end
         end
      end
   end

   ////////////////////
   // Host model, reply serialiser

   int         snd_cnt = -1;
   logic [9:0] snd_bits;

   always @(posedge clk) begin
      if (snd_cnt < 0) begin
         if (reply_q.size() > 0) begin
            snd_bits = {1'b1, reply_q.pop_front(), 1'b0};
            snd_cnt  = 0;
            i_rx    <= 1'b0;
         end
      end else begin
         snd_cnt++;
         if (snd_cnt == FRAME_CLKS) begin
            snd_cnt = -1;
         end else begin
            i_rx <= snd_bits[snd_cnt / CLKS_PER_BIT];
         end
      end
   end

   ////////////////////
   // Scoreboard

   task automatic check_accept(input int c, input bit wr);
      logic [DATA_WIDTH-1:0] exp;
      acc_order.push_back(c);
      assert (fr_wr.size() > 0) else begin
         $display("Accept from client %0d arrived with no frame seen on the line", c);
         errors++;
      end
      if (fr_wr.size() > 0) begin
         assert (fr_wr[0] == wr && fr_addr[0] == c_addr[c] && (!wr || fr_data[0] == c_wdata[c]))
         else begin
            $display("FAILED %0t: client %0d frame wr %0b addr %h data %h, sent %0b %h %h",
                     $time, c, fr_wr[0], fr_addr[0], fr_data[0], wr, c_addr[c], c_wdata[c]);
            errors++;
         end
         void'(fr_wr.pop_front());
         void'(fr_addr.pop_front());
         void'(fr_data.pop_front());
      end
      if (wr) begin
         ref_mem[c_addr[c]] = c_wdata[c];
      end else begin
         exp = ref_mem.exists(c_addr[c]) ? ref_mem[c_addr[c]] : '0;
         assert (c_rdata[c] == exp) else begin
            $display("FAILED %0t: client %0d read %h got %h, expected %h", $time, c,
                     c_addr[c], c_rdata[c], exp);
            errors++;
         end
      end
   endtask

   always @(posedge clk) begin
      for (int c = 0; c < NUM_CLIENTS; c++) begin
         if (nRst && (rd_acc[c] || wr_acc[c])) begin
            check_accept(c, wr_acc[c]);
         end
      end
   end

   ////////////////////
   // Client driver, called on a rising edge

   task automatic access(input int c, input bit wr, input logic [15:0] addr,
                         input logic [15:0] data);
      int cnt;
      cnt = 0;
      c_addr[c]  <= addr;
      c_wdata[c] <= data;
      c_wv[c]    <= wr;
      c_rv[c]    <= !wr;
      do begin
         @(posedge clk);
         cnt++;
      end while (!(rd_acc[c] || wr_acc[c]) && cnt < TIMEOUT);
      if (cnt >= TIMEOUT) begin
         $display("Client %0d got no accept within %0d cycles, the bridge hangs", c, TIMEOUT);
         errors++;
         finish_run();
      end else begin
         c_wv[c] <= 1'b0;
         c_rv[c] <= 1'b0;
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      // Scoreboard finishes the accept seen on the previous edge
      @(posedge clk);
      tests_run++;
      if (errors != err_before) tests_failed++;
      $display("test %-22s %s", name, (errors == err_before) ? "pass" : "fail");
   endtask

   logic [15:0] op_addr [2][75];
   logic [15:0] op_data [2][75];
   bit          op_wr [2][75];

   initial begin
      int e;
      nRst = 1'b0;
      i_rx = 1'b1;
      for (int c = 0; c < 2; c++) begin
         c_addr[c]  = '0;
         c_wdata[c] = '0;
         c_rv[c]    = 1'b0;
         c_wv[c]    = 1'b0;
      end
      repeat (10) @(posedge clk);
      nRst <= 1'b1;

      e = errors;
      repeat (20) @(posedge clk);
      assert (!rd_acc[0] && !wr_acc[0] && !rd_acc[1] && !wr_acc[1] && o_tx) else begin
         $display("FAILED %0t: accepts or o_tx wrong after reset", $time);
         errors++;
      end
      end_test("reset state", e);

      e = errors;
      access(1, 1, 16'h1234, 16'hbeef);
      access(1, 0, 16'h1234, 16'h0000);
      end_test("write then read", e);

      e = errors;
      for (int i = 0; i < 6; i++) begin
         access(0, lcg_next() & 1, lcg_next() & 16'hffff, lcg_next() & 16'hffff);
      end
      end_test("frame format", e);

      e = errors;
      acc_order.delete();
      fork
         for (int i = 0; i < 4; i++) access(0, 0, 16'h1234, 16'h0);
         for (int i = 0; i < 4; i++) access(1, 0, 16'h0010 + i, 16'h0);
      join
      // Last accept is recorded by the scoreboard on this edge
      @(posedge clk);
      assert (acc_order.size() == 8) else begin
         $display("FAILED %0t: %0d accepts seen, expected 8", $time, acc_order.size());
         errors++;
      end
      for (int i = 1; i < acc_order.size(); i++) begin
         assert (acc_order[i] != acc_order[i-1]) else begin
            $display("FAILED %0t: client %0d served twice in a row", $time, acc_order[i]);
            errors++;
         end
      end
      end_test("arbitration", e);

      e = errors;
      corrupt_next = 1;
      access(0, 0, 16'h1234, 16'h0);
      end_test("corrupted reply", e);

      e = errors;
      for (int c = 0; c < 2; c++) begin
         for (int i = 0; i < 75; i++) begin
            op_wr[c][i]   = lcg_next() & 1;
            op_addr[c][i] = 16'h0040 + (lcg_next() & 7);
            op_data[c][i] = lcg_next() & 16'hffff;
         end
      end
      fork
         for (int i = 0; i < 75; i++) access(0, op_wr[0][i], op_addr[0][i], op_data[0][i]);
         for (int i = 0; i < 75; i++) access(1, op_wr[1][i], op_addr[1][i], op_data[1][i]);
      join
      // Last accept is matched to its frame on this edge
      @(posedge clk);
      assert (fr_wr.size() == 0) else begin
         $display("Frames seen on the line without a matching accept: %0d", fr_wr.size());
         errors++;
      end
      end_test("random mixed traffic", e);

      finish_run();
   end

endmodule
